//--- source/palette_pkg.sv
package palette_pkg;

  // Stored palette entry is RGB565
  localparam int COLOUR_W = 16;

  // Width of the byte address carried on the pixel path
  localparam int PIX_ADDR_W = 16;

  typedef struct packed {
    logic sof; // First pixel of a frame
    logic eol; // Last pixel of a line
  } pix_tag_t;

  typedef struct packed {
    logic [PIX_ADDR_W-1:0] addr; // Table byte address
    pix_tag_t              tag;
  } pix_addr_t;

  typedef struct packed {
    logic [COLOUR_W-1:0] colour; // R[15:11] G[10:5] B[4:0]
    pix_tag_t            tag;
  } pix_565_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    pix_tag_t   tag;
  } pix_888_t;

  // Write response state of the colour table
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_t;

endpackage

//--- source/pixel_index_gen.sv
module pixel_index_gen #(
  parameter int OFFSET     = 0,
  parameter int ADDR_WIDTH = 16,
  parameter int H_ACTIVE   = 640,
  parameter int V_ACTIVE   = 480
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   index_valid,
  input  logic [7:0]             index,
  output logic                   addr_valid,
  output palette_pkg::pix_addr_t addr_out
);

  import palette_pkg::*;

  localparam int H_W = $clog2(H_ACTIVE + 1);
  localparam int V_W = $clog2(V_ACTIVE + 1);

  logic [H_W-1:0]        h_cnt;
  logic [V_W-1:0]        v_cnt;
  logic                  h_last;
  logic                  v_last;
  logic [ADDR_WIDTH-1:0] byte_addr;
  pix_tag_t              tag_next;

  assign h_last = (h_cnt == H_W'(H_ACTIVE - 1));
  assign v_last = (v_cnt == V_W'(V_ACTIVE - 1));

  // Two bytes per RGB565 entry
  assign byte_addr = ADDR_WIDTH'(OFFSET) + ADDR_WIDTH'({index, 1'b0});

  assign tag_next.sof = (h_cnt == '0) && (v_cnt == '0);
  assign tag_next.eol = h_last;

  // Raster position advances only on a valid index
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      h_cnt      <= '0;
      v_cnt      <= '0;
      addr_valid <= 1'b0;
    end else begin
      addr_valid <= index_valid;
      if (index_valid) begin
        if (h_last) begin
          h_cnt <= '0;
          v_cnt <= v_last ? '0 : v_cnt + 1'b1; // Wrap at end of frame
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    addr_out.addr <= PIX_ADDR_W'(byte_addr);
    addr_out.tag  <= tag_next;
  end

endmodule

//--- source/axil_colour_table.sv
module axil_colour_table #(
  parameter int OFFSET       = 0,
  parameter int ADDR_WIDTH   = 16,
  parameter int DATA_WIDTH   = palette_pkg::COLOUR_W,
  parameter int MEMORY_DEPTH = 4096
) (
  input  logic                    aclk,
  input  logic                    aresetn,

  input  logic [ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic                    s_axil_awvalid,
  output logic                    s_axil_awready,

  input  logic [DATA_WIDTH-1:0]   s_axil_wdata,
  input  logic                    s_axil_wvalid,
  output logic                    s_axil_wready,

  output logic                    s_axil_bvalid,
  input  logic                    s_axil_bready,

  input  logic [ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic                    s_axil_arvalid,
  output logic                    s_axil_arready,

  output logic [DATA_WIDTH-1:0]   s_axil_rdata,
  output logic [1:0]              s_axil_rresp,
  output logic                    s_axil_rvalid,
  input  logic                    s_axil_rready,

  input  logic                    addr_valid,
  input  palette_pkg::pix_addr_t  addr_in,
  output logic                    colour_valid,
  output palette_pkg::pix_565_t   colour_out
);

  import palette_pkg::*;

  localparam int IDX_W = $clog2(MEMORY_DEPTH);

  // Unwritten entries read back as zero
  bit [DATA_WIDTH-1:0] mem [MEMORY_DEPTH];

  logic                  aw_hs;
  logic                  w_hs;
  logic                  ar_hs;
  logic [ADDR_WIDTH-1:0] aw_addr;
  logic [ADDR_WIDTH-1:0] aw_rel;
  logic [ADDR_WIDTH-1:0] ar_addr;
  logic [ADDR_WIDTH-1:0] ar_rel;
  logic [PIX_ADDR_W-1:0] pb_rel;
  wr_state_t             wr_state;
  logic                  wr_pending;
  logic                  rd_pending;
  logic                  rd_load;

  assign aw_hs = s_axil_awvalid && s_axil_awready;
  assign w_hs  = s_axil_wvalid && s_axil_wready;
  assign ar_hs = s_axil_arvalid && s_axil_arready;

  assign s_axil_rresp  = 2'b00; // Always OKAY
  assign s_axil_bvalid = (wr_state == WR_RESP);

  // Live address is used when address and data share a cycle
  assign aw_rel = (aw_hs ? s_axil_awaddr : aw_addr) - ADDR_WIDTH'(OFFSET);
  assign ar_rel = ar_addr - ADDR_WIDTH'(OFFSET);
  assign pb_rel = addr_in.addr - PIX_ADDR_W'(OFFSET);

  // Address and data channels are always ready once out of reset
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      s_axil_arready <= 1'b0;
    end else begin
      s_axil_awready <= 1'b1;
      s_axil_wready  <= 1'b1;
      s_axil_arready <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      aw_addr <= s_axil_awaddr;
    end
    if (ar_hs) begin
      ar_addr <= s_axil_araddr;
    end
  end

  always_ff @(posedge aclk) begin
    if (w_hs) begin
      mem[aw_rel[IDX_W:1]] <= s_axil_wdata; // Whole entry, no strobes
    end
  end

  // One response per write; a write landing during a response waits
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_state   <= WR_IDLE;
      wr_pending <= 1'b0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (w_hs || wr_pending) begin
            wr_state <= WR_RESP;
          end
          wr_pending <= w_hs && wr_pending;
        end
        WR_RESP: begin
          if (s_axil_bready) begin
            wr_state <= WR_IDLE; // Drop for a cycle before the next one
          end
          wr_pending <= wr_pending || w_hs;
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // Data register loads when the slot is empty or being emptied
  assign rd_load = rd_pending && (!s_axil_rvalid || s_axil_rready);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_pending    <= 1'b0;
      s_axil_rvalid <= 1'b0;
    end else begin
      if (ar_hs) begin
        rd_pending <= 1'b1;
      end else if (rd_load) begin
        rd_pending <= 1'b0;
      end
      if (rd_load) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rvalid && s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_load) begin
      s_axil_rdata <= mem[ar_rel[IDX_W:1]]; // Held under back-pressure
    end
  end

  // Pixel port reads the colour one cycle after the address
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      colour_valid <= 1'b0;
    end else begin
      colour_valid <= addr_valid;
    end
  end

  always_ff @(posedge aclk) begin
    colour_out.colour <= COLOUR_W'(mem[pb_rel[IDX_W:1]]);
    colour_out.tag    <= addr_in.tag;
  end

endmodule

//--- source/rgb_expand.sv
module rgb_expand (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  colour_valid,
  input  palette_pkg::pix_565_t colour_in,
  output logic                  pix_valid,
  output palette_pkg::pix_888_t pix_out
);

  import palette_pkg::*;

  logic [4:0] red5;
  logic [5:0] grn6;
  logic [4:0] blu5;
  pix_888_t   pix_next;

  // Split the RGB565 entry
  assign red5 = colour_in.colour[15:11];
  assign grn6 = colour_in.colour[10:5];
  assign blu5 = colour_in.colour[4:0];

  // Top bits repeated into the low end so full scale maps to 8'hff
  assign pix_next.r   = {red5, red5[4:2]};
  assign pix_next.g   = {grn6, grn6[5:4]};
  assign pix_next.b   = {blu5, blu5[4:2]};
  assign pix_next.tag = colour_in.tag; // Markers ride along unchanged

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= colour_valid;
    end
  end

  always_ff @(posedge aclk) begin
    pix_out <= pix_next;
  end

endmodule

//--- source/video_palette_top.sv
module video_palette_top #(
  parameter int OFFSET       = 0,
  parameter int ADDR_WIDTH   = 16,
  parameter int MEMORY_DEPTH = 4096,
  parameter int H_ACTIVE     = 640,
  parameter int V_ACTIVE     = 480
) (
  input  logic                            aclk,
  input  logic                            aresetn,

  input  logic [ADDR_WIDTH-1:0]           s_axil_awaddr,
  input  logic                            s_axil_awvalid,
  output logic                            s_axil_awready,
  input  logic [palette_pkg::COLOUR_W-1:0] s_axil_wdata,
  input  logic                            s_axil_wvalid,
  output logic                            s_axil_wready,
  output logic                            s_axil_bvalid,
  input  logic                            s_axil_bready,
  input  logic [ADDR_WIDTH-1:0]           s_axil_araddr,
  input  logic                            s_axil_arvalid,
  output logic                            s_axil_arready,
  output logic [palette_pkg::COLOUR_W-1:0] s_axil_rdata,
  output logic [1:0]                      s_axil_rresp,
  output logic                            s_axil_rvalid,
  input  logic                            s_axil_rready,

  input  logic                            index_valid,
  input  logic [7:0]                      index,
  output logic                            pix_valid,
  output palette_pkg::pix_888_t           pix_out
);

  import palette_pkg::*;

  logic      addr_valid;
  pix_addr_t pix_addr;
  logic      colour_valid;
  pix_565_t  colour;

  // Producer turns each index into a byte address with raster markers
  pixel_index_gen #(
    .OFFSET    (OFFSET),
    .ADDR_WIDTH(ADDR_WIDTH),
    .H_ACTIVE  (H_ACTIVE),
    .V_ACTIVE  (V_ACTIVE)
  ) u_index_gen (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .index_valid(index_valid),
    .index      (index),
    .addr_valid (addr_valid),
    .addr_out   (pix_addr)
  );

  axil_colour_table #(
    .OFFSET      (OFFSET),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (COLOUR_W),
    .MEMORY_DEPTH(MEMORY_DEPTH)
  ) u_colour_table (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axil_awaddr (s_axil_awaddr),
    .s_axil_awvalid(s_axil_awvalid),
    .s_axil_awready(s_axil_awready),
    .s_axil_wdata  (s_axil_wdata),
    .s_axil_wvalid (s_axil_wvalid),
    .s_axil_wready (s_axil_wready),
    .s_axil_bvalid (s_axil_bvalid),
    .s_axil_bready (s_axil_bready),
    .s_axil_araddr (s_axil_araddr),
    .s_axil_arvalid(s_axil_arvalid),
    .s_axil_arready(s_axil_arready),
    .s_axil_rdata  (s_axil_rdata),
    .s_axil_rresp  (s_axil_rresp),
    .s_axil_rvalid (s_axil_rvalid),
    .s_axil_rready (s_axil_rready),
    .addr_valid    (addr_valid),
    .addr_in       (pix_addr),
    .colour_valid  (colour_valid),
    .colour_out    (colour)
  );

  // Consumer widens RGB565 to RGB888
  rgb_expand u_rgb_expand (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .colour_valid(colour_valid),
    .colour_in   (colour),
    .pix_valid   (pix_valid),
    .pix_out     (pix_out)
  );

endmodule

//--- tb/tb_video_palette.sv
module tb_video_palette;

  import palette_pkg::*;

  localparam int H_ACTIVE = 8;
  localparam int V_ACTIVE = 4;
  localparam int MAX_OPS  = 64;

  logic        aclk;
  logic        aresetn;
  logic [15:0] s_axil_awaddr;
  logic        s_axil_awvalid;
  logic        s_axil_awready;
  logic [15:0] s_axil_wdata;
  logic        s_axil_wvalid;
  logic        s_axil_wready;
  logic        s_axil_bvalid;
  logic        s_axil_bready;
  logic [15:0] s_axil_araddr;
  logic        s_axil_arvalid;
  logic        s_axil_arready;
  logic [15:0] s_axil_rdata;
  logic [1:0]  s_axil_rresp;
  logic        s_axil_rvalid;
  logic        s_axil_rready;
  logic        index_valid;
  logic [7:0]  index;
  logic        pix_valid;
  pix_888_t    pix_out;

  logic [7:0]  op_mem [MAX_OPS];
  logic [31:0] a_mem [MAX_OPS];
  logic [31:0] b_mem [MAX_OPS];
  int          n_mem [MAX_OPS];
  int          n_ops;
  int          limit;
  int          cyc;
  int          errors;
  int          n_writes;
  int          bresp_cnt;
  int          pix_cnt;
  int          seed = 60;
  bit          loaded;
  pix_888_t    exp_q [$];   // Expected pixels in issue order
  int          issue_q [$]; // Cycle each index was taken

  video_palette_top #(
    .OFFSET  (0),
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
  ) dut (.*);

  always #2 aclk = ~aclk;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic log_failure(input string what);
    $display("At time %0t: %s", $time, what);
    errors++;
  endtask

  // Columns are op, address or index, data or expected value, and a run length for P
  task automatic load_stim(output bit ok);
    int          fd;
    int          r;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    int          n;
    fd = $fopen("tb/palette_stim.txt", "r");
    ok = (fd != 0);
    n_ops = 0;
    if (ok) begin
      while (n_ops < MAX_OPS && $fscanf(fd, " %s %h %h", op, a, b) == 3) begin
        n = 1;
        if (op == "P") begin
          r = $fscanf(fd, " %d", n);
          if (r != 1) ok = 1'b0; // Run length missing
        end
        op_mem[n_ops] = op;
        a_mem[n_ops]  = a;
        b_mem[n_ops]  = b;
        n_mem[n_ops]  = n;
        n_ops++;
      end
      $fclose(fd);
    end
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
    int d;
    s_axil_awaddr  <= addr[15:0];
    s_axil_awvalid <= 1'b1;
    s_axil_wdata   <= data[15:0];
    s_axil_wvalid  <= 1'b1;
    do @(posedge aclk); while (!(s_axil_awready && s_axil_wready));
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    n_writes++;
    while (s_axil_bvalid !== 1'b1) @(posedge aclk);
    d = $random(seed) & 3; // Response back-pressure
    repeat (d) @(posedge aclk);
    s_axil_bready <= 1'b1;
    @(posedge aclk);
    s_axil_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [31:0] expected);
    int          d;
    logic [15:0] held;
    s_axil_araddr  <= addr[15:0];
    s_axil_arvalid <= 1'b1;
    do @(posedge aclk); while (!s_axil_arready);
    s_axil_arvalid <= 1'b0;
    while (s_axil_rvalid !== 1'b1) @(posedge aclk);
    held = s_axil_rdata;
    d = $random(seed) & 3;
    repeat (d) begin
      @(posedge aclk);
      if (s_axil_rvalid !== 1'b1) log_failure("rvalid dropped while rready was low");
      if (s_axil_rdata !== held) report_mismatch("s_axil_rdata", 32'(held), 32'(s_axil_rdata));
    end
    s_axil_rready <= 1'b1;
    @(posedge aclk);
    s_axil_rready <= 1'b0;
    if (held !== expected[15:0]) report_mismatch("s_axil_rdata", expected, 32'(held));
    if (s_axil_rresp !== 2'b00) report_mismatch("s_axil_rresp", 32'd0, 32'(s_axil_rresp));
  endtask

  task automatic send_pixel(input logic [31:0] idx, input logic [31:0] rgb);
    pix_888_t p;
    p.r       = rgb[23:16];
    p.g       = rgb[15:8];
    p.b       = rgb[7:0];
    p.tag.sof = (pix_cnt % (H_ACTIVE * V_ACTIVE) == 0);
    p.tag.eol = (pix_cnt % H_ACTIVE == H_ACTIVE - 1);
    exp_q.push_back(p);
    pix_cnt++;
    index_valid <= 1'b1;
    index       <= idx[7:0];
    @(posedge aclk);
  endtask

  // Monitor sees the values from before each edge
  always @(posedge aclk) begin
    pix_888_t want;
    int       t_in;
    logic     rdy_exp;
    cyc = cyc + 1;
    rdy_exp = (cyc >= 18); // Channels open from the first cycle out of reset
    if (cyc >= 2 && cyc <= 18) begin // Reset and the cycles right after
      if (s_axil_bvalid !== 1'b0) report_mismatch("s_axil_bvalid", 32'd0, 32'(s_axil_bvalid));
      if (s_axil_rvalid !== 1'b0) report_mismatch("s_axil_rvalid", 32'd0, 32'(s_axil_rvalid));
      if (pix_valid !== 1'b0) report_mismatch("pix_valid", 32'd0, 32'(pix_valid));
    end
    if (cyc >= 2) begin
      if (s_axil_awready !== rdy_exp) begin
        report_mismatch("s_axil_awready", 32'(rdy_exp), 32'(s_axil_awready));
      end
      if (s_axil_wready !== rdy_exp) begin
        report_mismatch("s_axil_wready", 32'(rdy_exp), 32'(s_axil_wready));
      end
    end
    if (cyc >= 18 && s_axil_arready !== 1'b1) begin
      report_mismatch("s_axil_arready", 32'd1, 32'(s_axil_arready));
    end
    if (s_axil_bvalid === 1'b1 && s_axil_bready) bresp_cnt++;
    if (aresetn && index_valid) issue_q.push_back(cyc);
    if (pix_valid === 1'b1) begin
      if (exp_q.size() == 0 || issue_q.size() == 0) begin
        log_failure("pix_valid seen with no pixel outstanding");
      end else begin
        want = exp_q.pop_front();
        t_in = issue_q.pop_front();
        if (pix_out !== want) report_mismatch("pix_out", 32'(want), 32'(pix_out));
        if (cyc - t_in != 3) report_mismatch("pixel latency", 32'd3, 32'(cyc - t_in));
      end
    end
    if (cyc > limit) begin
      $display("Run stopped after %0d cycles without finishing the stimulus", cyc);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    aclk = 1'b0;
    aresetn        <= 1'b0;
    s_axil_awaddr  <= '0;
    s_axil_awvalid <= 1'b0;
    s_axil_wdata   <= '0;
    s_axil_wvalid  <= 1'b0;
    s_axil_bready  <= 1'b0;
    s_axil_araddr  <= '0;
    s_axil_arvalid <= 1'b0;
    s_axil_rready  <= 1'b0;
    index_valid    <= 1'b0;
    index          <= '0;
    load_stim(loaded);
    limit = 40 * n_ops + 200;
    if (!loaded || n_ops == 0) begin
      $display("The stim file tb/palette_stim.txt is missing, empty or malformed");
      $display("Done: errors found");
      $finish;
    end else begin
      repeat (16) @(posedge aclk);
      aresetn <= 1'b1;
      @(posedge aclk);
      for (int i = 0; i < n_ops; i++) begin
        if (op_mem[i] != "P") index_valid <= 1'b0; // Consecutive P lines form one burst
        case (op_mem[i])
          "W": axi_write(a_mem[i], b_mem[i]);
          "R": axi_read(a_mem[i], b_mem[i]);
          "P": repeat (n_mem[i]) send_pixel(a_mem[i], b_mem[i]);
          default: log_failure("unknown operation letter in stim file");
        endcase
      end
      index_valid <= 1'b0;
      while (exp_q.size() != 0) @(posedge aclk);
      if (bresp_cnt != n_writes) report_mismatch("write responses", n_writes, bresp_cnt);
      $display("Errors %0d, writes %0d, responses %0d, pixels %0d",
               errors, n_writes, bresp_cnt, pix_cnt);
      if (errors == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

//--- tb/palette_stim.txt
W 0000 f800
W 0002 07e0
W 0004 001f
W 0006 ffff
W 0008 8410
W 000a 1234
W 000c abcd
W 0006 7bef
R 0000 f800
R 0006 7bef
R 000c abcd
R 000e 0000
R 0100 0000
R 000a 1234
P 00 ff0000 4
P 01 00ff00 4
P 02 0000ff 4
P 03 7b7d7b 4
P 04 848284 4
P 05 1045a5 4
P 06 ad796b 4
P 07 000000 4

//--- flist.f
source/palette_pkg.sv
source/pixel_index_gen.sv
source/axil_colour_table.sv
source/rgb_expand.sv
source/video_palette_top.sv
tb/tb_video_palette.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_video_palette
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
